// File: Makefile
VERILATOR  ?= verilator
TOP        ?= afu_cmd_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
rtl/afu_cmd_pkg.sv
rtl/cmd_link_if.sv
rtl/round_robin_arb.sv
rtl/cmd_arbiter_n_to_1.sv
rtl/cmd_credit_stage.sv
rtl/rsp_router_1_to_n.sv
rtl/afu_cmd_top.sv
sim/afu_cmd_tb.sv

// File: rtl/afu_cmd_pkg.sv
package afu_cmd_pkg;

  ////////////////////////////////////////
  // widths shared by all stages
  ////////////////////////////////////////

  // command address width
  localparam int ADDR_W = 16;

  // response payload width
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  ////////////////////////////////////////
  // command opcodes
  ////////////////////////////////////////

  // two bit encoding as sent on the outbound port
  typedef enum logic [1:0] {
    CMD_READ  = 2'd0,
    CMD_WRITE = 2'd1,
    CMD_TOUCH = 2'd2,
    CMD_FLUSH = 2'd3
  } cmd_opcode_t;

endpackage

// File: rtl/afu_cmd_top.sv
`timescale 1ns/1ps

module afu_cmd_top #(
  parameter int  NUM_REQUESTS = 4,
  parameter int  MAX_CREDITS  = 3,
  localparam int TAG_W        = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1
) (
  input  logic                      clock,
  input  logic                      rstn,
  // compute unit requests
  input  logic [NUM_REQUESTS-1:0]   req,
  input  afu_cmd_pkg::cmd_opcode_t  req_opcode [NUM_REQUESTS],
  input  afu_cmd_pkg::addr_t        req_addr [NUM_REQUESTS],
  output logic [NUM_REQUESTS-1:0]   ready,
  // outbound command port
  output logic                      cmd_valid,
  output logic [TAG_W-1:0]          cmd_tag,
  output afu_cmd_pkg::cmd_opcode_t  cmd_opcode,
  output afu_cmd_pkg::addr_t        cmd_addr,
  // inbound response port
  input  logic                      rsp_valid,
  input  logic [TAG_W-1:0]          rsp_tag,
  input  afu_cmd_pkg::data_t        rsp_data,
  // per compute unit completion
  output logic [NUM_REQUESTS-1:0]   done,
  output afu_cmd_pkg::data_t        done_data [NUM_REQUESTS]
);

  // arbiter to credit stage
  cmd_link_if #(.NUM_REQUESTS(NUM_REQUESTS)) link ();

  cmd_arbiter_n_to_1 #(
    .NUM_REQUESTS (NUM_REQUESTS)
  ) u_arbiter (
    .clock      (clock),
    .rstn       (rstn),
    .req        (req),
    .req_opcode (req_opcode),
    .req_addr   (req_addr),
    .ready      (ready),
    .link       (link.arb)
  );

  // responses return the credits
  cmd_credit_stage #(
    .NUM_REQUESTS (NUM_REQUESTS),
    .MAX_CREDITS  (MAX_CREDITS)
  ) u_credit (
    .clock      (clock),
    .rstn       (rstn),
    .link       (link.credit),
    .rsp_valid  (rsp_valid),
    .cmd_valid  (cmd_valid),
    .cmd_tag    (cmd_tag),
    .cmd_opcode (cmd_opcode),
    .cmd_addr   (cmd_addr)
  );

  rsp_router_1_to_n #(
    .NUM_REQUESTS (NUM_REQUESTS)
  ) u_router (
    .clock     (clock),
    .rstn      (rstn),
    .rsp_valid (rsp_valid),
    .rsp_tag   (rsp_tag),
    .rsp_data  (rsp_data),
    .done      (done),
    .done_data (done_data)
  );

endmodule

// File: rtl/cmd_arbiter_n_to_1.sv
`timescale 1ns/1ps

module cmd_arbiter_n_to_1 #(
  parameter int NUM_REQUESTS = 4
) (
  input  logic                      clock,
  input  logic                      rstn,
  input  logic [NUM_REQUESTS-1:0]   req,
  input  afu_cmd_pkg::cmd_opcode_t  req_opcode [NUM_REQUESTS],
  input  afu_cmd_pkg::addr_t        req_addr [NUM_REQUESTS],
  output logic [NUM_REQUESTS-1:0]   ready,
  cmd_link_if.arb                   link
);
  import afu_cmd_pkg::*;

  localparam int TAG_W = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

  logic [NUM_REQUESTS-1:0] grants;
  logic [TAG_W-1:0]        win_tag;
  cmd_opcode_t             win_opcode;
  addr_t                   win_addr;

  // pointer only moves while a credit lets the grant through
  round_robin_arb #(
    .NUM_REQUESTS (NUM_REQUESTS)
  ) u_rr_arb (
    .clock  (clock),
    .rstn   (rstn),
    .en     (link.enabled),
    .reqs   (req),
    .grants (grants)
  );

  // ready the winner only with a free credit
  assign ready     = grants & {NUM_REQUESTS{link.enabled}};
  assign link.take = |ready;

  ////////////////////////////////////////
  // winner mux, zero when idle
  ////////////////////////////////////////

  always_comb begin
    win_tag    = '0;
    win_opcode = CMD_READ;
    win_addr   = '0;
    for (int i = 0; i < NUM_REQUESTS; i++) begin
      if (ready[i]) begin
        win_tag    = TAG_W'(i);
        win_opcode = req_opcode[i];
        win_addr   = req_addr[i];
      end
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      link.valid <= 1'b0;
    end else begin
      link.valid <= link.take;
    end
  end

  // fields follow the valid bit, zero on idle cycles
  always_ff @(posedge clock) begin
    link.tag    <= win_tag;
    link.opcode <= win_opcode;
    link.addr   <= win_addr;
  end

  // a waiting unit keeps its request and command stable until its ready
  for (genvar g = 0; g < NUM_REQUESTS; g++) begin : g_req_hold
    a_req_held: assert property (@(posedge clock) disable iff (!rstn)
      (req[g] && !ready[g]) |=>
        (req[g] && $stable(req_opcode[g]) && $stable(req_addr[g])));
  end

endmodule

// File: rtl/cmd_credit_stage.sv
`timescale 1ns/1ps

module cmd_credit_stage #(
  parameter int  NUM_REQUESTS = 4,
  parameter int  MAX_CREDITS  = 3,
  localparam int TAG_W        = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1
) (
  input  logic                      clock,
  input  logic                      rstn,
  cmd_link_if.credit                link,
  input  logic                      rsp_valid,
  output logic                      cmd_valid,
  output logic [TAG_W-1:0]          cmd_tag,
  output afu_cmd_pkg::cmd_opcode_t  cmd_opcode,
  output afu_cmd_pkg::addr_t        cmd_addr
);

  localparam int CNT_W = $clog2(MAX_CREDITS + 1);

  // free credits, full after reset
  logic [CNT_W-1:0] credit_cnt;

  ////////////////////////////////////////
  // credit counter
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      credit_cnt <= CNT_W'(MAX_CREDITS);
    end else begin
      // take and response together cancel out
      case ({link.take, rsp_valid})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  assign link.enabled = (credit_cnt != '0);

  ////////////////////////////////////////
  // issue register
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= link.valid;
    end
  end

  // tag already stamped by the arbiter, fields are zero when idle
  always_ff @(posedge clock) begin
    cmd_tag    <= link.tag;
    cmd_opcode <= link.opcode;
    cmd_addr   <= link.addr;
  end

  // a response always has an outstanding command behind it
  a_credit_overflow: assert property (@(posedge clock) disable iff (!rstn)
    (rsp_valid && !link.take) |-> (credit_cnt < CNT_W'(MAX_CREDITS)));

  // arbiter never consumes a grant with the count empty
  a_credit_underflow: assert property (@(posedge clock) disable iff (!rstn)
    link.take |-> (credit_cnt != '0));

endmodule

// File: rtl/cmd_link_if.sv
`timescale 1ns/1ps

interface cmd_link_if #(
  parameter int NUM_REQUESTS = 4
);
  import afu_cmd_pkg::*;

  // tag carries the index of the winning compute unit
  localparam int TAG_W = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

  // high while the credit stage has a free credit
  logic              enabled;
  // one cycle pulse per consumed grant
  logic              take;
  // registered winner, one cycle after its ready
  logic              valid;
  logic [TAG_W-1:0]  tag;
  cmd_opcode_t       opcode;
  addr_t             addr;

  modport arb (output take, valid, tag, opcode, addr, input enabled);

  modport credit (input take, valid, tag, opcode, addr, output enabled);

endinterface

// File: rtl/round_robin_arb.sv
`timescale 1ns/1ps

module round_robin_arb #(
  parameter int NUM_REQUESTS = 4
) (
  input  logic                    clock,
  input  logic                    rstn,
  input  logic                    en,
  input  logic [NUM_REQUESTS-1:0] reqs,
  output logic [NUM_REQUESTS-1:0] grants
);

  localparam int PTR_W = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

  // highest priority request this cycle
  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] win_idx;
  logic             found;

  ////////////////////////////////////////
  // cyclic search from the pointer
  ////////////////////////////////////////

  always_comb begin
    int idx;
    grants  = '0;
    win_idx = '0;
    found   = 1'b0;
    for (int off = 0; off < NUM_REQUESTS; off++) begin
      // wrap the index back to request 0
      idx = (int'(ptr) + off) % NUM_REQUESTS;
      if (!found && reqs[idx]) begin
        found       = 1'b1;
        grants[idx] = 1'b1;
        win_idx     = PTR_W'(idx);
      end
    end
  end

  // winner drops to lowest priority, only once its grant is used
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      ptr <= '0;
    end else if (en && found) begin
      if (win_idx == PTR_W'(NUM_REQUESTS - 1)) begin
        ptr <= '0;
      end else begin
        ptr <= win_idx + 1'b1;
      end
    end
  end

  // never more than one winner
  a_grants_onehot: assert property (@(posedge clock) disable iff (!rstn)
    $onehot0(grants));

endmodule

// File: rtl/rsp_router_1_to_n.sv
`timescale 1ns/1ps

module rsp_router_1_to_n #(
  parameter int  NUM_REQUESTS = 4,
  localparam int TAG_W        = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1
) (
  input  logic                    clock,
  input  logic                    rstn,
  input  logic                    rsp_valid,
  input  logic [TAG_W-1:0]        rsp_tag,
  input  afu_cmd_pkg::data_t      rsp_data,
  output logic [NUM_REQUESTS-1:0] done,
  output afu_cmd_pkg::data_t      done_data [NUM_REQUESTS]
);
  import afu_cmd_pkg::*;

  // stage one, one-hot lane and the payload
  logic [NUM_REQUESTS-1:0] sel_q;
  data_t                   data_q;
  logic [NUM_REQUESTS-1:0] sel_dec;

  // single response per cycle, so a plain tag decode picks the lane
  always_comb begin
    sel_dec = '0;
    if (rsp_valid) begin
      sel_dec[rsp_tag] = 1'b1;
    end
  end

  ////////////////////////////////////////
  // stage one
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      sel_q <= '0;
    end else begin
      sel_q <= sel_dec;
    end
  end

  always_ff @(posedge clock) begin
    data_q <= rsp_data;
  end

  ////////////////////////////////////////
  // stage two, lane outputs
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      done <= '0;
    end else begin
      done <= sel_q;
    end
  end

  // unselected lanes are forced to zero
  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_REQUESTS; i++) begin
      done_data[i] <= sel_q[i] ? data_q : '0;
    end
  end

  a_done_onehot: assert property (@(posedge clock) disable iff (!rstn)
    $onehot0(done));

endmodule

// File: sim/afu_cmd_tb.sv
`timescale 1ns/1ps

module afu_cmd_tb;
  import afu_cmd_pkg::*;

  localparam int NUM_REQUESTS = 4;
  localparam int MAX_CREDITS = 3;
  localparam int TAG_W = $clog2(NUM_REQUESTS);
  localparam int NUM_CMDS = 200;
  localparam int RESET_CYCLES = 16;
  localparam int HOLD_CYCLES = 12;
  localparam int CLK_PERIOD = 8;
  // 20 cycles per command plus reset
  localparam int WATCHDOG_CYCLES = NUM_CMDS * 20 + RESET_CYCLES;

  logic clock = 1'b0;
  logic rstn = 1'b0;
  logic [NUM_REQUESTS-1:0] req = '0;
  cmd_opcode_t req_opcode [NUM_REQUESTS] = '{default: CMD_READ};
  addr_t req_addr [NUM_REQUESTS] = '{default: '0};
  logic rsp_valid = 1'b0;
  logic [TAG_W-1:0] rsp_tag = '0;
  data_t rsp_data = '0;
  logic [NUM_REQUESTS-1:0] ready;
  logic cmd_valid;
  logic [TAG_W-1:0] cmd_tag;
  cmd_opcode_t cmd_opcode;
  addr_t cmd_addr;
  logic [NUM_REQUESTS-1:0] done;
  data_t done_data [NUM_REQUESTS];

  int seed = 77735;
  // model state
  int ptr = 0;
  int free = MAX_CREDITS;
  int launched = 0;
  int issued = 0;
  int hold_issues = 0;
  int responses = 0;
  int overlaps = 0;
  int checks = 0;
  int errors = 0;
  int rsp_wait = 0;
  int cycle = 0;
  logic run = 1'b0;
  // responses withheld in the first phase
  logic hold_rsp = 1'b1;
  logic [NUM_REQUESTS-1:0] served = '0;
  logic [TAG_W-1:0] rsp_q [$];
  // index 0 is one cycle old, index 1 two cycles old
  logic iss_valid [2] = '{default: 1'b0};
  logic [TAG_W-1:0] iss_tag [2] = '{default: '0};
  cmd_opcode_t iss_opc [2] = '{default: CMD_READ};
  addr_t iss_addr [2] = '{default: '0};
  logic rsp_seen [2] = '{default: 1'b0};
  logic [TAG_W-1:0] rsp_seen_tag [2] = '{default: '0};
  data_t rsp_seen_data [2] = '{default: '0};

  always #(CLK_PERIOD / 2) clock = ~clock;

  afu_cmd_top #(.NUM_REQUESTS(NUM_REQUESTS), .MAX_CREDITS(MAX_CREDITS)) UUT (
    .clock(clock), .rstn(rstn), .req(req), .req_opcode(req_opcode), .req_addr(req_addr),
    .ready(ready), .cmd_valid(cmd_valid), .cmd_tag(cmd_tag), .cmd_opcode(cmd_opcode),
    .cmd_addr(cmd_addr), .rsp_valid(rsp_valid), .rsp_tag(rsp_tag), .rsp_data(rsp_data),
    .done(done), .done_data(done_data)
  );

  task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERR %s: expected %0h actual %0h", name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // compute units and response device
  ////////////////////////////////////////

  always @(posedge clock) begin
    if (run) begin
      // a unit holds its command until ready, then may present a new one
      for (int i = 0; i < NUM_REQUESTS; i++) begin
        if (!req[i] || served[i]) begin
          if (launched < NUM_CMDS && (hold_rsp || ($random(seed) & 3) != 0)) begin
            req[i]        <= 1'b1;
            req_opcode[i] <= cmd_opcode_t'(2'($random(seed)));
            req_addr[i]   <= ADDR_W'($random(seed));
            launched++;
          end else begin
            req[i] <= 1'b0;
          end
        end
      end
      // issued tags come back in order after 0 to 5 idle cycles
      rsp_valid <= 1'b0;
      if (!hold_rsp && rsp_q.size() > 0) begin
        if (rsp_wait == 0) begin
          rsp_valid <= 1'b1;
          rsp_tag   <= rsp_q.pop_front();
          rsp_data  <= $random(seed);
          rsp_wait = int'($unsigned($random(seed)) % 6);
        end else begin
          rsp_wait--;
        end
      end
    end
  end

  ////////////////////////////////////////
  // reference model, one step per cycle
  ////////////////////////////////////////

  task automatic model_step();
    logic [NUM_REQUESTS-1:0] exp_ready;
    logic [NUM_REQUESTS-1:0] exp_done;
    int win;
    int idx;
    exp_ready = '0;
    exp_done = '0;
    win = -1;
    // first pending request at or after the pointer, only with a free credit
    if (free > 0) begin
      for (int off = 0; off < NUM_REQUESTS; off++) begin
        idx = (ptr + off) % NUM_REQUESTS;
        if (win < 0 && req[idx]) begin
          win = idx;
        end
      end
    end
    if (win >= 0) begin
      exp_ready[win] = 1'b1;
    end
    check_value("fairness ready", 64'(exp_ready), 64'(ready));
    assert (free > 0 || ready == '0) else begin
      errors++;
      $display("ready given while all %0d credits were outstanding", MAX_CREDITS);
    end
    // issue two cycles after ready
    check_value("issue valid", 64'(iss_valid[1]), 64'(cmd_valid));
    if (iss_valid[1] && cmd_valid) begin
      check_value("issue tag", 64'(iss_tag[1]), 64'(cmd_tag));
      check_value("issue opcode", 64'(iss_opc[1]), 64'(cmd_opcode));
      check_value("issue addr", 64'(iss_addr[1]), 64'(cmd_addr));
    end
    if (cmd_valid) begin
      rsp_q.push_back(cmd_tag);
      issued++;
      if (hold_rsp) begin
        hold_issues++;
      end
    end
    // done lane two cycles after the response
    if (rsp_seen[1]) begin
      exp_done[rsp_seen_tag[1]] = 1'b1;
      responses++;
    end
    check_value("route done", 64'(exp_done), 64'(done));
    for (int i = 0; i < NUM_REQUESTS; i++) begin
      check_value($sformatf("route data lane %0d", i),
                  exp_done[i] ? 64'(rsp_seen_data[1]) : 64'(0), 64'(done_data[i]));
    end
    // take and return in one cycle cancel out
    if (win >= 0 && rsp_valid) begin
      overlaps++;
    end
    if (win >= 0) begin
      ptr = (win + 1) % NUM_REQUESTS;
      free--;
    end
    if (rsp_valid) begin
      free++;
    end
    iss_valid[1] = iss_valid[0];
    iss_tag[1]   = iss_tag[0];
    iss_opc[1]   = iss_opc[0];
    iss_addr[1]  = iss_addr[0];
    iss_valid[0] = (win >= 0);
    iss_tag[0]   = (win >= 0) ? TAG_W'(win) : '0;
    iss_opc[0]   = (win >= 0) ? req_opcode[win] : CMD_READ;
    iss_addr[0]  = (win >= 0) ? req_addr[win] : '0;
    rsp_seen[1]      = rsp_seen[0];
    rsp_seen_tag[1]  = rsp_seen_tag[0];
    rsp_seen_data[1] = rsp_seen_data[0];
    rsp_seen[0]      = rsp_valid;
    rsp_seen_tag[0]  = rsp_tag;
    rsp_seen_data[0] = rsp_data;
    served = ready;
  endtask

  initial begin
    repeat (RESET_CYCLES) @(posedge clock);
    rstn <= 1'b1;
    @(negedge clock);
    // outputs quiet out of reset
    check_value("reset ready", 64'(0), 64'(ready));
    check_value("reset cmd_valid", 64'(0), 64'(cmd_valid));
    check_value("reset done", 64'(0), 64'(done));
    run = 1'b1;
    while (!(issued == NUM_CMDS && responses == NUM_CMDS)) begin
      @(negedge clock);
      model_step();
      cycle++;
      // end of the withheld phase, the path must have stalled
      if (cycle == HOLD_CYCLES) begin
        check_value("credit limit", 64'(MAX_CREDITS), 64'(hold_issues));
        assert (req != '0 && ready == '0) else begin
          errors++;
          $display("requests were not held off once the credits ran out");
        end
        hold_rsp = 1'b0;
      end
    end
    assert (overlaps > 0) else begin
      errors++;
      $display("no cycle had a take and a response together");
    end
    $display("summary: checks=%0d errors=%0d issued=%0d responses=%0d overlaps=%0d",
             checks, errors, issued, responses, overlaps);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, %0d of %0d commands issued",
             WATCHDOG_CYCLES, issued, NUM_CMDS);
    $display("summary: checks=%0d errors=%0d", checks, errors);
    $display("Test FAILED");
    $finish;
  end

endmodule
